// ==== files.f ====
design/icache_pkg.sv
design/icache_fill_if.sv
design/icache_way.sv
design/icache_hit_select.sv
design/icache_refill.sv
design/icache.sv
bench/axi_mem_model.sv
bench/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - design/icache_pkg.sv
      - design/icache_fill_if.sv
      - design/icache_way.sv
      - design/icache_hit_select.sv
      - design/icache_refill.sv
      - design/icache.sv
  - target: test
    files:
      - bench/axi_mem_model.sv
      - bench/icache_tb.sv

// ==== bench/icache_tb.sv ====
`timescale 1ns/100ps

module icache_tb
	import icache_pkg::*;
();

	localparam logic [31:0] SEED = 32'ha195;
	localparam int CLK_PERIOD = 100;
	// outputs are read a quarter period after the falling edge
	localparam int SAMPLE_DELAY = CLK_PERIOD / 4;
	localparam int RESET_CYCLES = 10;
	localparam int TABLE_LEN = 21;
	localparam int CYCLES_PER_FETCH = 200;
	localparam int TIMEOUT_CYCLES = TABLE_LEN * CYCLES_PER_FETCH + 100;

	typedef struct packed
	{
		addr_t addr;
		logic miss;
	} fetch_entry_t;

	// tag | index | offset, outcome follows 2-way lru
	localparam fetch_entry_t FETCH_TABLE [TABLE_LEN] = '{
		// cold miss, set 5 into way 0
		'{32'h0001_014C, 1'b1},
		'{32'h0001_0140, 1'b0},
		'{32'h0001_017C, 1'b0},
		'{32'h0001_015C, 1'b0},
		// second tag of set 5 into way 1
		'{32'h0002_0144, 1'b1},
		'{32'h0001_0148, 1'b0},
		'{32'h0002_0164, 1'b0},
		// third tag evicts tag 0x10 (lru)
		'{32'h0003_0140, 1'b1},
		'{32'h0002_0150, 1'b0},
		// evicted tag comes back, pushes out 0x30
		'{32'h0001_014C, 1'b1},
		'{32'h0003_0140, 1'b1},
		'{32'h0001_0178, 1'b0},
		'{32'h0002_0140, 1'b1},
		// top set and set 0
		'{32'hABCD_EFFC, 1'b1},
		'{32'hABCD_EFC0, 1'b0},
		'{32'h0000_0000, 1'b1},
		'{32'h0000_0004, 1'b0},
		'{32'hABCD_EFE0, 1'b0},
		'{32'h0002_0154, 1'b0},
		'{32'h0003_0144, 1'b1},
		'{32'h0001_014C, 1'b1}
	};

	logic clk;
	logic rst_n;
	logic cpu_re;
	addr_t cpu_addr;
	word_t cpu_rdata;
	logic cpu_stall;
	logic if_id_stall;
	logic if_clr;
	logic req;
	logic gnt;
	addr_t araddr;
	logic arvalid;
	logic arready;
	word_t rdata;
	logic rvalid;
	logic rready;

	// word still due from the previous fetch
	logic word_pending;
	word_t pending_word;
	int cycle_count = 0;

	icache UUT (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_re(cpu_re),
		.cpu_addr(cpu_addr),
		.cpu_rdata(cpu_rdata),
		.cpu_stall(cpu_stall),
		.if_id_stall(if_id_stall),
		.if_clr(if_clr),
		.req(req),
		.gnt(gnt),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid),
		.rready(rready)
	);

	axi_mem_model #(.SEED(SEED)) u_mem (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.gnt(gnt),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid),
		.rready(rready)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp)
		begin
			$display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string what);
		if (got !== exp)
		begin
			$display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	// one fetch, stall cycles checked one by one
	task automatic run_fetch(input addr_t addr, input logic exp_miss);
		int cyc;
		logic ar_seen;
		addr_t line_base;
		cyc = 0;
		ar_seen = 1'b0;
		line_base = {addr[ADDR_WIDTH-1:LINE_WIDTH], {LINE_WIDTH{1'b0}}};
		@(negedge clk);
		cpu_re = 1'b1;
		cpu_addr = addr;
		#(SAMPLE_DELAY);
		// previous word comes out during this lookup
		if (word_pending)
		begin
			check_word(cpu_rdata, pending_word, "cpu_rdata");
		end
		check_bit(cpu_stall, exp_miss, "cpu_stall on lookup");
		while (cpu_stall)
		begin
			// cycle 0 is the miss itself, the fsm is still idle
			check_bit(if_clr, cyc == 1, "if_clr");
			check_bit(if_id_stall, cyc != 0, "if_id_stall");
			check_bit(req, cyc != 0, "req");
			if (arvalid)
			begin
				check_addr(araddr, line_base, "araddr");
				ar_seen = 1'b1;
			end
			cyc++;
			@(negedge clk);
			#(SAMPLE_DELAY);
		end
		// hit cycle, no bus activity
		check_bit(req, 1'b0, "req on hit");
		check_bit(if_id_stall, 1'b0, "if_id_stall on hit");
		check_bit(if_clr, 1'b0, "if_clr on hit");
		check_bit(ar_seen, exp_miss, "line address sent");
		// memory rule: inverted byte address
		word_pending = 1'b1;
		pending_word = ~{addr[ADDR_WIDTH-1:2], 2'b00};
	endtask

	// hang guard
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the cache never finished a fetch within %0d cycles",
				TIMEOUT_CYCLES);
			abort_run();
		end
	end

	initial
	begin
		rst_n = 1'b0;
		cpu_re = 1'b0;
		cpu_addr = '0;
		word_pending = 1'b0;
		pending_word = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		#(SAMPLE_DELAY);
		check_bit(req, 1'b0, "req after reset");
		check_bit(arvalid, 1'b0, "arvalid after reset");
		check_bit(rready, 1'b0, "rready after reset");
		check_bit(if_clr, 1'b0, "if_clr after reset");
		check_bit(cpu_stall, 1'b0, "cpu_stall after reset");
		check_bit(if_id_stall, 1'b0, "if_id_stall after reset");
		for (int i = 0; i < TABLE_LEN; i++)
		begin
			run_fetch(FETCH_TABLE[i].addr, FETCH_TABLE[i].miss);
		end
		// sweep the whole top-set line, back-to-back hits
		for (int off = 0; off < BEATS_PER_LINE; off++)
		begin
			run_fetch(32'hABCD_EFC0 + addr_t'(4 * off), 1'b0);
		end
		// drain the last word
		@(negedge clk);
		cpu_re = 1'b0;
		#(SAMPLE_DELAY);
		check_word(cpu_rdata, pending_word, "cpu_rdata");
		check_bit(cpu_stall, 1'b0, "cpu_stall when idle");
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== bench/axi_mem_model.sv ====
`timescale 1ns/100ps

module axi_mem_model
	import icache_pkg::*;
#(
	parameter logic [31:0] SEED = 32'h1,
	parameter int MAX_GNT_DELAY = 5,
	parameter int MAX_BEAT_GAP = 3
)
(
	input logic clk,
	input logic rst_n,
	// arbiter side
	input logic req,
	output logic gnt,
	// axi read address
	input addr_t araddr,
	input logic arvalid,
	output logic arready,
	// axi read data
	output word_t rdata,
	output logic rvalid,
	input logic rready
);

	// one complete refill: grant, address, 16 beats
	task automatic serve_burst();
		int unsigned delay;
		int unsigned gap;
		addr_t base;
		// arbiter answers after a random delay
		delay = $urandom % (MAX_GNT_DELAY + 1);
		repeat (delay) @(negedge clk);
		gnt = 1'b1;
		// wait for the line address
		while (!arvalid)
		begin
			@(negedge clk);
		end
		base = araddr;
		arready = 1'b1;
		@(negedge clk);
		arready = 1'b0;
		for (int i = 0; i < BEATS_PER_LINE; i++)
		begin
			// random idle gap ahead of each beat
			gap = $urandom % (MAX_BEAT_GAP + 1);
			rvalid = 1'b0;
			repeat (gap) @(negedge clk);
			rvalid = 1'b1;
			// memory holds the inverted byte address
			rdata = ~(base + addr_t'(4 * i));
			// hold the beat until the cache takes it
			while (!rready)
			begin
				@(negedge clk);
			end
			@(negedge clk);
		end
		rvalid = 1'b0;
		// grant stays up until the request drops
		while (req)
		begin
			@(negedge clk);
		end
		gnt = 1'b0;
	endtask

	initial
	begin
		gnt = 1'b0;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		// one seed for the whole run
		void'($urandom(SEED));
		forever
		begin
			@(negedge clk);
			if (rst_n && req)
			begin
				serve_burst();
			end
		end
	end

endmodule

// ==== design/icache.sv ====
`timescale 1ns/100ps

module icache
	import icache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	// cpu fetch side
	input logic cpu_re,
	input addr_t cpu_addr,
	output word_t cpu_rdata,
	output logic cpu_stall,
	output logic if_id_stall,
	output logic if_clr,
	// arbiter
	output logic req,
	input logic gnt,
	// axi read address
	output addr_t araddr,
	output logic arvalid,
	input logic arready,
	// axi read data
	input word_t rdata,
	input logic rvalid,
	output logic rready
);

	// fetch address fields, byte offset ignored
	tag_t cpu_tag;
	index_t cpu_index;
	offset_t cpu_offset;

	tag_t tag0;
	tag_t tag1;
	logic valid0;
	logic valid1;
	word_t word0;
	word_t word1;
	logic miss;
	logic victim;
	// refill in progress
	logic busy;

	assign cpu_tag = cpu_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
	assign cpu_index = cpu_addr[LINE_WIDTH +: INDEX_WIDTH];
	assign cpu_offset = cpu_addr[(LINE_WIDTH - OFFSET_WIDTH) +: OFFSET_WIDTH];

	// refill write bus to both ways and the lru
	icache_fill_if fill ();

	icache_way #(.WAY_ID(1'b0)) u_way0 (
		.clk(clk),
		.rst_n(rst_n),
		.rd_index(cpu_index),
		.rd_offset(cpu_offset),
		.fill(fill.sink),
		.line_tag(tag0),
		.line_valid(valid0),
		.rd_word(word0)
	);

	icache_way #(.WAY_ID(1'b1)) u_way1 (
		.clk(clk),
		.rst_n(rst_n),
		.rd_index(cpu_index),
		.rd_offset(cpu_offset),
		.fill(fill.sink),
		.line_tag(tag1),
		.line_valid(valid1),
		.rd_word(word1)
	);

	icache_hit_select u_hit_select (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_re(cpu_re),
		.index(cpu_index),
		.tag(cpu_tag),
		.tag0(tag0),
		.tag1(tag1),
		.valid0(valid0),
		.valid1(valid1),
		.word0(word0),
		.word1(word1),
		.fill(fill.monitor),
		.miss(miss),
		.victim(victim),
		.cpu_rdata(cpu_rdata)
	);

	icache_refill u_refill (
		.clk(clk),
		.rst_n(rst_n),
		.miss(miss),
		.victim(victim),
		.index(cpu_index),
		.tag(cpu_tag),
		.fill(fill.master),
		.req(req),
		.gnt(gnt),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid),
		.rready(rready),
		.if_clr(if_clr),
		.busy(busy)
	);

	// stall in the miss cycle itself, not one later
	assign cpu_stall = busy || miss;
	assign if_id_stall = busy;

endmodule

// ==== design/icache_refill.sv ====
`timescale 1ns/100ps

module icache_refill
	import icache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic miss,
	input logic victim,
	input index_t index,
	input tag_t tag,
	icache_fill_if.master fill,
	output logic req,
	input logic gnt,
	output addr_t araddr,
	output logic arvalid,
	input logic arready,
	input word_t rdata,
	input logic rvalid,
	output logic rready,
	output logic if_clr,
	output logic busy
);

	refill_state_t state;
	refill_state_t state_next;
	// missing line, held for the whole refill
	tag_t tag_q;
	index_t index_q;
	logic victim_q;
	// word offset of the next beat
	offset_t beat_cnt;
	// one R transfer accepted this cycle
	logic beat_ok;
	logic beat_last;

	assign beat_ok = rvalid && ((state == DATA_FIRST) || (state == DATA));
	assign beat_last = beat_ok && (beat_cnt == offset_t'(BEATS_PER_LINE - 1));

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
			begin
				if (miss)
				begin
					state_next = BUS_WAIT;
				end
			end
			BUS_WAIT:
			begin
				// grant may come any number of cycles later
				if (gnt)
				begin
					state_next = ADDR_SEND;
				end
			end
			ADDR_SEND:
			begin
				if (arready)
				begin
					state_next = DATA_FIRST;
				end
			end
			DATA_FIRST:
			begin
				if (beat_ok)
				begin
					state_next = DATA;
				end
			end
			DATA:
			begin
				// gaps just hold here
				if (beat_last)
				begin
					state_next = FILL_DONE;
				end
			end
			FILL_DONE:
			begin
				state_next = IDLE;
			end
			default:
			begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			beat_cnt <= '0;
			if_clr <= 1'b0;
		end
		else
		begin
			state <= state_next;
			// single pulse on leaving idle
			if_clr <= (state == IDLE) && miss;
			if (state == IDLE)
			begin
				beat_cnt <= '0;
			end
			else if (beat_ok)
			begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	// capture the miss when the fsm leaves idle
	always_ff @(posedge clk)
	begin
		if ((state == IDLE) && miss)
		begin
			tag_q <= tag;
			index_q <= index;
			victim_q <= victim;
		end
	end

	assign busy = (state != IDLE);
	// bus held from the cycle after the miss through fill_done
	assign req = busy;
	assign arvalid = (state == ADDR_SEND);
	// never throttle the burst
	assign rready = (state == DATA_FIRST) || (state == DATA) || (state == FILL_DONE);

	// line base, word and byte offsets zero
	assign araddr = {tag_q, index_q, {LINE_WIDTH{1'b0}}};

	// every accepted beat goes straight into the victim way
	assign fill.we = beat_ok;
	assign fill.way = victim_q;
	assign fill.index = index_q;
	assign fill.offset = beat_cnt;
	assign fill.tag = tag_q;
	assign fill.data = rdata;
	assign fill.last = beat_last;

	// a beat outside the data phase would be lost
	a_no_early_beat: assert property (
		@(posedge clk) disable iff (!rst_n)
		rvalid |-> rready
	);

	// arbiter keeps the grant while the bus is requested
	a_gnt_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		(req && gnt) |=> (gnt || !req)
	);

endmodule

// ==== design/icache_hit_select.sv ====
`timescale 1ns/100ps

module icache_hit_select
	import icache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic cpu_re,
	input index_t index,
	input tag_t tag,
	input tag_t tag0,
	input tag_t tag1,
	input logic valid0,
	input logic valid1,
	input word_t word0,
	input word_t word1,
	icache_fill_if.monitor fill,
	output logic miss,
	output logic victim,
	output word_t cpu_rdata
);

	// per set: the least recently used way
	logic [NUM_SETS-1:0] lru;
	logic hit0;
	logic hit1;
	// hit flags aligned with the registered way data
	logic hit0_q;
	logic hit1_q;

	// a way hits only with a valid line and matching tag
	assign hit0 = valid0 && (tag0 == tag);
	assign hit1 = valid1 && (tag1 == tag);

	assign miss = cpu_re && !hit0 && !hit1;

	// replace whichever way was touched longer ago
	assign victim = lru[index];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			lru <= '0;
		end
		else
		begin
			// hit: the other way becomes lru
			if (cpu_re && (hit0 || hit1))
			begin
				lru[index] <= hit0 ? 1'b1 : 1'b0;
			end
			// freshly filled way counts as used
			if (fill.we && fill.last)
			begin
				lru[fill.index] <= ~fill.way;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hit0_q <= 1'b0;
			hit1_q <= 1'b0;
		end
		else
		begin
			hit0_q <= hit0;
			hit1_q <= hit1;
		end
	end

	// way 0 first, then way 1, else zero
	assign cpu_rdata = hit0_q ? word0 : (hit1_q ? word1 : '0);

	// a line must never live in both ways of a set
	a_single_way_hit: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(hit0 && hit1)
	);

endmodule

// ==== design/icache_way.sv ====
`timescale 1ns/100ps

module icache_way
	import icache_pkg::*;
#(
	parameter bit WAY_ID = 1'b0
)
(
	input logic clk,
	input logic rst_n,
	input index_t rd_index,
	input offset_t rd_offset,
	icache_fill_if.sink fill,
	output tag_t line_tag,
	output logic line_valid,
	output word_t rd_word
);

	// one valid bit per set
	logic [NUM_SETS-1:0] valid;
	tag_t tag_mem [NUM_SETS];
	// line storage, set then word
	word_t data_mem [NUM_SETS][BEATS_PER_LINE];
	// fill beat aimed at this way
	logic wr_sel;

	assign wr_sel = fill.we && (fill.way == WAY_ID);

	// valid bits
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid <= '0;
		end
		else if (wr_sel)
		begin
			// line only becomes visible once all 16 words are in
			if (fill.last)
			begin
				valid[fill.index] <= 1'b1;
			end
			// first beat kills the old line so a partial refill can't hit
			else if (fill.offset == '0)
			begin
				valid[fill.index] <= 1'b0;
			end
		end
	end

	// tag and data writes
	always_ff @(posedge clk)
	begin
		if (wr_sel)
		begin
			tag_mem[fill.index] <= fill.tag;
			data_mem[fill.index][fill.offset] <= fill.data;
		end
	end

	// registered word read, one cycle behind the address
	always_ff @(posedge clk)
	begin
		rd_word <= data_mem[rd_index][rd_offset];
	end

	// tag and valid read straight from the index
	assign line_tag = tag_mem[rd_index];
	assign line_valid = valid[rd_index];

	// the refill counter must flag its final word as last
	a_last_on_final_word: assert property (
		@(posedge clk) disable iff (!rst_n)
		(wr_sel && (fill.offset == offset_t'(BEATS_PER_LINE - 1))) |-> fill.last
	);

endmodule

// ==== design/icache_fill_if.sv ====
`timescale 1ns/100ps

interface icache_fill_if
	import icache_pkg::*;
();
	// one strobe per accepted beat
	logic we;
	// victim way
	logic way;
	index_t index;
	offset_t offset;
	tag_t tag;
	word_t data;
	// final beat, sets valid
	logic last;

	modport master (output we, way, index, offset, tag, data, last);

	modport sink (input we, way, index, offset, tag, data, last);

	// lru tracker only needs to know where the line landed
	modport monitor (input we, way, index, last);

endinterface

// ==== design/icache_pkg.sv ====
package icache_pkg;

	// fetch and bus address width
	localparam int ADDR_WIDTH = 32;

	// address split: tag | index | word offset | byte offset
	localparam int TAG_WIDTH = 20;
	// bits addressing inside one line
	localparam int LINE_WIDTH = 6;
	localparam int INDEX_WIDTH = ADDR_WIDTH - TAG_WIDTH - LINE_WIDTH;
	// word select inside a line, byte offset dropped
	localparam int OFFSET_WIDTH = LINE_WIDTH - 2;

	// 64 sets per way
	localparam int NUM_SETS = 2 ** INDEX_WIDTH;
	// one AXI burst fills one line
	localparam int BEATS_PER_LINE = 2 ** OFFSET_WIDTH;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [TAG_WIDTH-1:0] tag_t;
	typedef logic [INDEX_WIDTH-1:0] index_t;
	typedef logic [OFFSET_WIDTH-1:0] offset_t;

	// miss handling sequence
	typedef enum logic [2:0]
	{
		// waiting for a miss
		IDLE,
		// req up, waiting for gnt
		BUS_WAIT,
		// arvalid held until arready
		ADDR_SEND,
		// first beat clears the victim's valid bit
		DATA_FIRST,
		// remaining beats
		DATA,
		// line valid, one cycle before release
		FILL_DONE
	} refill_state_t;

endpackage
